// ==== sources.f ====
logic/mod_switch_pkg.sv
logic/const_mult.sv
logic/mod_switch_pow2.sv
logic/coef_fifo.sv
logic/coef_packer.sv
logic/mod_switch_top.sv
tests/mod_switch_checker.sv
tests/tb_mod_switch.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the modulus-switch testbench with Verilator

BUILD_DIR=obj_dir
LOG_FILE=sim.log

cd "$(dirname "$0")" || exit 1

# Compile with assertions and timing support
verilator --binary --timing --assert \
  --top-module tb_mod_switch \
  --Mdir "$BUILD_DIR" -o tb_mod_switch \
  -f sources.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

# Run the simulation, keep the whole output in the log
"./$BUILD_DIR/tb_mod_switch" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

# The log decides the result
if grep -q "^Done: no errors$" "$LOG_FILE"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG_FILE"
  exit 1
fi

// ==== tests/tb_mod_switch.sv ====
`timescale 1ns/1ps

module tb_mod_switch
  import mod_switch_pkg::*;
();

  logic               clk;
  logic               s_rst_n;
  logic [MOD_P_W-1:0] a;
  logic               in_avail;
  logic [SIDE_W-1:0]  in_side;
  logic               drain;
  logic [PACK_W-1:0]  pack_word;
  logic [SIDE_W-1:0]  pack_side;
  logic               pack_avail;
  logic               fifo_full;
  logic               overflow;

  integer             seed = 65;
  logic [SIDE_W-1:0]  tag;

  mod_switch_top mod_switch_top_inst (
    .clk(clk), .s_rst_n(s_rst_n), .a(a), .in_avail(in_avail), .in_side(in_side),
    .drain(drain), .pack_word(pack_word), .pack_side(pack_side),
    .pack_avail(pack_avail), .fifo_full(fifo_full), .overflow(overflow)
  );

  mod_switch_checker checker_inst (
    .clk(clk), .s_rst_n(s_rst_n), .in_avail(in_avail), .a(a), .in_side(in_side),
    .pack_avail(pack_avail), .pack_word(pack_word), .pack_side(pack_side)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // -------------------------------------------------------------------
  // Stimulus helpers
  // -------------------------------------------------------------------
  // All inputs change on the falling edge
  function automatic logic [MOD_P_W-1:0] random_coef();
    return {$random(seed)} % MOD_P;
  endfunction

  task automatic send_coef(input logic [MOD_P_W-1:0] value);
    @(negedge clk);
    a        = value;
    in_avail = 1'b1;
    in_side  = tag;
    tag      = tag + 1'b1;
  endtask

  task automatic go_idle();
    @(negedge clk);
    in_avail = 1'b0;
  endtask

  // Wait until every expected coefficient has been packed and compared
  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while (checker_inst.pending_count() != 0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (checker_inst.pending_count() != 0) begin
      checker_inst.report_problem("timed out waiting for the packed words to come out");
    end
  endtask

  task automatic wait_full(input int limit);
    int n;
    n = 0;
    while (fifo_full !== 1'b1 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (fifo_full !== 1'b1) begin
      checker_inst.report_problem("timed out waiting for fifo_full to go high");
    end
  endtask

  task automatic wait_overflow(input int limit);
    int n;
    n = 0;
    while (overflow !== 1'b1 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (overflow !== 1'b1) begin
      checker_inst.report_problem("timed out waiting for overflow to go high");
    end
  endtask

  // -------------------------------------------------------------------
  // Test sequence
  // -------------------------------------------------------------------
  initial begin
    int          i;
    int          sent;
    logic [31:0] r;
    s_rst_n  = 1'b0;
    a        = '0;
    in_avail = 1'b0;
    in_side  = '0;
    drain    = 1'b0;
    tag      = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    s_rst_n = 1'b1;

    checker_inst.begin_test("edge_values");
    drain = 1'b1;
    send_coef('0);
    send_coef(MOD_P_W'(1));
    send_coef(MOD_P - 1'b1);
    send_coef(MOD_P / 2);
    go_idle();
    wait_drained(100);
    checker_inst.end_test();

    checker_inst.begin_test("random_stream");
    for (i = 0; i < 200; i++) begin
      send_coef(random_coef());
    end
    go_idle();
    wait_drained(1000);
    checker_inst.end_test();

    // Eight entries fill the FIFO exactly
    checker_inst.begin_test("back_pressure");
    drain = 1'b0;
    for (i = 0; i < 8; i++) begin
      send_coef(random_coef());
    end
    go_idle();
    wait_full(20);
    checker_inst.compare_value("overflow while full", '0, PACK_W'(overflow));
    drain = 1'b1;
    wait_drained(100);
    checker_inst.compare_value("overflow after drain", '0, PACK_W'(overflow));
    checker_inst.end_test();

    checker_inst.begin_test("overflow");
    drain = 1'b0;
    for (i = 0; i < 11; i++) begin
      send_coef(random_coef());
    end
    go_idle();
    // Last three writes land on a full FIFO
    checker_inst.drop_newest(3);
    // Producer latency, the last write reaches the FIFO three edges later
    repeat (3) @(negedge clk);
    wait_overflow(20);
    drain = 1'b1;
    wait_drained(100);
    checker_inst.end_test();

    checker_inst.begin_test("random_gaps");
    sent = 0;
    for (i = 0; i < 300; i++) begin
      @(negedge clk);
      r        = $random(seed);
      a        = random_coef();
      in_side  = tag;
      in_avail = r[0];
      // Forced high when many are pending, so the FIFO never fills
      drain    = r[1] || (checker_inst.pending_count() >= 5);
      if (r[0]) begin
        tag  = tag + 1'b1;
        sent = sent + 1;
      end
    end
    // Odd count would leave a half pair in the packer
    if (sent % 2 != 0) begin
      send_coef(random_coef());
    end
    go_idle();
    drain = 1'b1;
    wait_drained(200);
    checker_inst.end_test();

    checker_inst.begin_test("reset_mid_stream");
    for (i = 0; i < 5; i++) begin
      send_coef(random_coef());
    end
    @(negedge clk);
    in_avail = 1'b0;
    s_rst_n  = 1'b0;
    repeat (2) @(negedge clk);
    s_rst_n = 1'b1;
    checker_inst.compare_value("pack_avail after reset", '0, PACK_W'(pack_avail));
    checker_inst.compare_value("overflow after reset", '0, PACK_W'(overflow));
    send_coef(random_coef());
    send_coef(random_coef());
    go_idle();
    wait_drained(100);
    checker_inst.end_test();

    checker_inst.final_report();
    if (checker_inst.error_total() == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== tests/mod_switch_checker.sv ====
`timescale 1ns/1ps

module mod_switch_checker
  import mod_switch_pkg::*;
(
  input  logic               clk,
  input  logic               s_rst_n,
  input  logic               in_avail,
  input  logic [MOD_P_W-1:0] a,
  input  logic [SIDE_W-1:0]  in_side,
  input  logic               pack_avail,
  input  logic [PACK_W-1:0]  pack_word,
  input  logic [SIDE_W-1:0]  pack_side
);

  // Queue entry holds the tag above the expected coefficient
  logic [SIDE_W+MOD_Q_W-1:0] exp_queue [$];
  logic [SIDE_W+MOD_Q_W-1:0] first_entry;
  logic [SIDE_W+MOD_Q_W-1:0] second_entry;
  logic                      last_avail = 1'b0;

  string test_name   = "reset";
  int    error_count = 0;
  int    check_count = 0;
  int    test_errors = 0;
  int    test_checks = 0;

  // -------------------------------------------------------------------
  // Reference model
  // -------------------------------------------------------------------
  // round(a * CST_MULT / 2^PRECISION_W) mod 2^MOD_Q_W
  function automatic logic [MOD_Q_W-1:0] expected_coef(input logic [MOD_P_W-1:0] coef);
    logic [PROD_W:0] scaled;
    scaled = (PROD_W+1)'(coef) * (PROD_W+1)'(CST_MULT);
    // Half an output LSB added first, then the fraction is dropped
    scaled = scaled + ((PROD_W+1)'(1) << (PRECISION_W - 1));
    return scaled[PRECISION_W +: MOD_Q_W];
  endfunction

  // -------------------------------------------------------------------
  // Bookkeeping used by the testbench
  // -------------------------------------------------------------------
  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
    test_checks = 0;
  endtask

  task automatic end_test();
    $display("%s %s: %0d checks, %0d errors",
             (test_errors == 0) ? "[PASS]" : "[FAIL]", test_name, test_checks, test_errors);
  endtask

  task automatic compare_value(input string what, input logic [PACK_W-1:0] expected,
                               input logic [PACK_W-1:0] actual);
    check_count++;
    test_checks++;
    if (expected !== actual) begin
      error_count++;
      test_errors++;
      $display("[ERROR] %s %s: expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic report_problem(input string msg);
    error_count++;
    test_errors++;
    $display("[ERROR] %s: %s", test_name, msg);
  endtask

  // Writes made while the FIFO was full never come out
  task automatic drop_newest(input int count);
    repeat (count) void'(exp_queue.pop_back());
  endtask

  function automatic int pending_count();
    return exp_queue.size();
  endfunction

  function automatic int error_total();
    return error_count;
  endfunction

  task automatic final_report();
    $display("Totals: %0d checks, %0d errors", check_count, error_count);
  endtask

  // -------------------------------------------------------------------
  // Monitor and compare
  // -------------------------------------------------------------------
  always @(posedge clk) begin
    if (!s_rst_n) begin
      // Reset flushes the pipeline, the FIFO and the packer
      exp_queue.delete();
      last_avail = 1'b0;
    end else begin
      if (pack_avail) begin
        if (last_avail) begin
          report_problem("pack_avail was high on two consecutive cycles");
        end
        if (exp_queue.size() < 2) begin
          report_problem("a packed word came out with fewer than two coefficients expected");
        end else begin
          first_entry  = exp_queue.pop_front();
          second_entry = exp_queue.pop_front();
          compare_value("low half", PACK_W'(first_entry[MOD_Q_W-1:0]),
                        PACK_W'(pack_word[MOD_Q_W-1:0]));
          compare_value("high half", PACK_W'(second_entry[MOD_Q_W-1:0]),
                        PACK_W'(pack_word[PACK_W-1:MOD_Q_W]));
          compare_value("tag", PACK_W'(first_entry[MOD_Q_W +: SIDE_W]), PACK_W'(pack_side));
        end
      end
      last_avail = pack_avail;
      // Every accepted input becomes one expected coefficient
      if (in_avail) begin
        exp_queue.push_back({in_side, expected_coef(a)});
      end
    end
  end

endmodule

// ==== logic/mod_switch_top.sv ====
`timescale 1ns/1ps

module mod_switch_top
  import mod_switch_pkg::*;
(
  input  logic               clk,
  input  logic               s_rst_n,

  input  logic [MOD_P_W-1:0] a,
  input  logic               in_avail,
  input  logic [SIDE_W-1:0]  in_side,
  input  logic               drain,

  output logic [PACK_W-1:0]  pack_word,
  output logic [SIDE_W-1:0]  pack_side,
  output logic               pack_avail,
  output logic               fifo_full,
  output logic               overflow
);

  // -------------------------------------------------------------------
  // Interconnect
  // -------------------------------------------------------------------
  // Producer to buffer
  logic [MOD_Q_W-1:0] ms_z;
  logic               ms_avail;
  logic [SIDE_W-1:0]  ms_side;

  // Buffer to packer
  logic [MOD_Q_W-1:0] rd_data;
  logic [SIDE_W-1:0]  rd_side;
  logic               rd_en;
  logic               empty;

  // Producer has a fixed three cycle latency and never stalls
  mod_switch_pow2 mod_switch_pow2_inst (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .a        (a),
    .in_avail (in_avail),
    .in_side  (in_side),
    .z        (ms_z),
    .out_avail(ms_avail),
    .out_side (ms_side)
  );

  // Every producer output is offered to the buffer
  coef_fifo coef_fifo_inst (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .wr_en   (ms_avail),
    .wr_data (ms_z),
    .wr_side (ms_side),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .rd_side (rd_side),
    .empty   (empty),
    .full    (fifo_full),
    .overflow(overflow)
  );

  // Consumer gated by the external drain level
  coef_packer coef_packer_inst (
    .clk       (clk),
    .s_rst_n   (s_rst_n),
    .drain     (drain),
    .empty     (empty),
    .rd_data   (rd_data),
    .rd_side   (rd_side),
    .rd_en     (rd_en),
    .pack_word (pack_word),
    .pack_side (pack_side),
    .pack_avail(pack_avail)
  );

endmodule

// ==== logic/coef_packer.sv ====
`timescale 1ns/1ps

module coef_packer
  import mod_switch_pkg::*;
(
  input  logic               clk,
  input  logic               s_rst_n,

  input  logic               drain,
  input  logic               empty,
  input  logic [MOD_Q_W-1:0] rd_data,
  input  logic [SIDE_W-1:0]  rd_side,

  output logic               rd_en,
  output logic [PACK_W-1:0]  pack_word,
  output logic [SIDE_W-1:0]  pack_side,
  output logic               pack_avail
);

  pack_state_e        state;

  // Low half held until its partner arrives
  logic [MOD_Q_W-1:0] low_coef;
  logic [SIDE_W-1:0]  low_side;

  // Pull one entry per cycle while allowed and data is there
  assign rd_en = drain && !empty;

  // -------------------------------------------------------------------
  // Pair FSM
  // -------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      state      <= PACK_LOW;
      pack_avail <= 1'b0;
      pack_side  <= '0;
      low_side   <= '0;
    end else begin
      pack_avail <= 1'b0;
      if (rd_en) begin
        case (state)
          PACK_LOW: begin
            low_side <= rd_side;
            state    <= PACK_HIGH;
          end
          PACK_HIGH: begin
            // Tag of the pair is the tag of its first coefficient
            pack_side  <= low_side;
            pack_avail <= 1'b1;
            state      <= PACK_LOW;
          end
          default: state <= PACK_LOW;
        endcase
      end
    end
  end

  // -------------------------------------------------------------------
  // Payload registers
  // -------------------------------------------------------------------
  // First coefficient goes in the low half
  always_ff @(posedge clk) begin
    if (rd_en && (state == PACK_LOW)) begin
      low_coef <= rd_data;
    end
    if (rd_en && (state == PACK_HIGH)) begin
      pack_word <= {rd_data, low_coef};
    end
  end

  // -------------------------------------------------------------------
  // Checks
  // -------------------------------------------------------------------
  // Two reads per word, so strobes are never adjacent
  a_no_back_to_back : assert property (
    @(posedge clk) disable iff (!s_rst_n)
    pack_avail |=> !pack_avail
  ) else $error("coef_packer: pack_avail on consecutive cycles");

endmodule

// ==== logic/coef_fifo.sv ====
`timescale 1ns/1ps

module coef_fifo
  import mod_switch_pkg::*;
(
  input  logic               clk,
  input  logic               s_rst_n,

  input  logic               wr_en,
  input  logic [MOD_Q_W-1:0] wr_data,
  input  logic [SIDE_W-1:0]  wr_side,

  input  logic               rd_en,
  output logic [MOD_Q_W-1:0] rd_data,
  output logic [SIDE_W-1:0]  rd_side,

  output logic               empty,
  output logic               full,
  output logic               overflow
);

  // -------------------------------------------------------------------
  // Storage and pointers
  // -------------------------------------------------------------------
  logic [MOD_Q_W-1:0]    mem_data [FIFO_DEPTH];
  logic [SIDE_W-1:0]     mem_side [FIFO_DEPTH];

  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  // Count needs one more bit to tell full from empty
  logic [FIFO_PTR_W:0]   count;

  logic                  wr_ok;
  logic                  rd_ok;

  assign empty = (count == '0);
  assign full  = (count == (FIFO_PTR_W+1)'(FIFO_DEPTH));

  // Writes into a full buffer are dropped
  assign wr_ok = wr_en && !full;
  assign rd_ok = rd_en && !empty;

  // Head entry is always on the read port
  assign rd_data = mem_data[rd_ptr];
  assign rd_side = mem_side[rd_ptr];

  // Memory write
  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem_data[wr_ptr] <= wr_data;
      mem_side[wr_ptr] <= wr_side;
    end
  end

  // -------------------------------------------------------------------
  // Pointer and occupancy update
  // -------------------------------------------------------------------
  // Depth is a power of two so the pointers wrap on their own
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous read and write leaves the count unchanged
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Any write attempt while full sets the flag until reset
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      overflow <= 1'b0;
    end else if (wr_en && full) begin
      overflow <= 1'b1;
    end
  end

  // -------------------------------------------------------------------
  // Checks
  // -------------------------------------------------------------------
  // Packer must look at empty before reading
  a_no_read_when_empty : assert property (
    @(posedge clk) disable iff (!s_rst_n)
    !(rd_en && empty)
  ) else $error("coef_fifo: read while empty");

endmodule

// ==== logic/mod_switch_pow2.sv ====
`timescale 1ns/1ps

module mod_switch_pow2
  import mod_switch_pkg::*;
(
  input  logic               clk,
  input  logic               s_rst_n,

  input  logic [MOD_P_W-1:0] a,
  input  logic               in_avail,
  input  logic [SIDE_W-1:0]  in_side,

  output logic [MOD_Q_W-1:0] z,
  output logic               out_avail,
  output logic [SIDE_W-1:0]  out_side
);

  // z = round(a * 2^MOD_Q_W / MOD_P), done as a multiply by CST_MULT
  // followed by dropping PRECISION_W fractional bits

  // -------------------------------------------------------------------
  // Stage 0 input register
  // -------------------------------------------------------------------
  logic [MOD_P_W-1:0] s0_a;
  logic               s0_avail;
  logic [SIDE_W-1:0]  s0_side;

  always_ff @(posedge clk) begin
    s0_a <= a;
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s0_avail <= 1'b0;
      s0_side  <= '0;
    end else begin
      s0_avail <= in_avail;
      s0_side  <= in_side;
    end
  end

  // -------------------------------------------------------------------
  // Stage 1 constant multiply
  // -------------------------------------------------------------------
  logic [PROD_W-1:0] s1_prod;
  logic              s1_avail;
  logic [SIDE_W-1:0] s1_side;

  const_mult const_mult_inst (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .x        (s0_a),
    .in_avail (s0_avail),
    .in_side  (s0_side),
    .prod     (s1_prod),
    .out_avail(s1_avail),
    .out_side (s1_side)
  );

  // Rounding on the highest discarded bit
  // The increment wraps modulo 2^MOD_Q_W
  logic [MOD_Q_W-1:0] s1_trunc;
  logic [MOD_Q_W-1:0] s1_result;

  assign s1_trunc  = s1_prod[PROD_W-2:PRECISION_W];
  assign s1_result = s1_trunc + MOD_Q_W'(s1_prod[PRECISION_W-1]);

  // -------------------------------------------------------------------
  // Stage 2 output register
  // -------------------------------------------------------------------
  always_ff @(posedge clk) begin
    z <= s1_result;
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      out_avail <= 1'b0;
      out_side  <= '0;
    end else begin
      out_avail <= s1_avail;
      out_side  <= s1_side;
    end
  end

  // -------------------------------------------------------------------
  // Checks
  // -------------------------------------------------------------------
  // Product MSB set means the input was not reduced mod p
  a_prod_msb_clear : assert property (
    @(posedge clk) disable iff (!s_rst_n)
    s1_avail |-> !s1_prod[PROD_W-1]
  ) else $error("mod_switch_pow2: product MSB set, overflow");

  // Upstream must only send reduced coefficients
  a_input_reduced : assert property (
    @(posedge clk) disable iff (!s_rst_n)
    s0_avail |-> (s0_a < MOD_P)
  ) else $error("mod_switch_pow2: input not below MOD_P");

endmodule

// ==== logic/const_mult.sv ====
`timescale 1ns/1ps

module const_mult
  import mod_switch_pkg::*;
(
  input  logic              clk,
  input  logic              s_rst_n,

  input  logic [MOD_P_W-1:0] x,
  input  logic               in_avail,
  input  logic [SIDE_W-1:0]  in_side,

  output logic [PROD_W-1:0]  prod,
  output logic               out_avail,
  output logic [SIDE_W-1:0]  out_side
);

  // -------------------------------------------------------------------
  // Product register
  // -------------------------------------------------------------------
  // Both operands widened to the product width before the multiply
  logic [PROD_W-1:0] x_ext;
  logic [PROD_W-1:0] cst_ext;

  assign x_ext   = PROD_W'(x);
  assign cst_ext = PROD_W'(CST_MULT);

  // Datapath register
  always_ff @(posedge clk) begin
    prod <= x_ext * cst_ext;
  end

  // -------------------------------------------------------------------
  // Strobe and tag delay
  // -------------------------------------------------------------------
  // Keeps avail and tag aligned with the product
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      out_avail <= 1'b0;
      out_side  <= '0;
    end else begin
      out_avail <= in_avail;
      out_side  <= in_side;
    end
  end

endmodule

// ==== logic/mod_switch_pkg.sv ====
package mod_switch_pkg;

  // -------------------------------------------------------------------
  // Coefficient widths and moduli
  // -------------------------------------------------------------------
  // Input prime p = 2^32 - 2^17 - 2^13 + 1
  localparam int                 MOD_P_W     = 32;
  localparam logic [MOD_P_W-1:0] MOD_P       = 32'hFFFD_E001;

  // Output modulus q is a power of two
  localparam int                 MOD_Q_W     = 32;

  // Extra fractional bits kept through the multiply
  localparam int                 PRECISION_W = 33;

  // -------------------------------------------------------------------
  // Multiplication constant floor(2^(MOD_Q_W+PRECISION_W) / MOD_P)
  // -------------------------------------------------------------------
  // One more bit is needed to hold the power of two itself
  localparam int                   CST_TMP_W = MOD_Q_W + PRECISION_W + 1;
  localparam logic [CST_TMP_W-1:0] CST_ONE   = 1;
  localparam logic [CST_TMP_W-1:0] CST_TMP   = (CST_ONE << (MOD_Q_W + PRECISION_W)) / MOD_P;

  localparam int                   CST_W     = MOD_Q_W + PRECISION_W - MOD_P_W + 1;
  localparam logic [CST_W-1:0]     CST_MULT  = CST_TMP[CST_W-1:0];

  // Top bit of the full product stays clear for inputs below MOD_P
  localparam int PROD_W = MOD_P_W + CST_W;

  // -------------------------------------------------------------------
  // Side tag, buffer and packer
  // -------------------------------------------------------------------
  localparam int SIDE_W     = 8;
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int PACK_W     = 2 * MOD_Q_W;

  // Packer waits first for the low half, then for the high half
  typedef enum logic {
    PACK_LOW  = 1'b0,
    PACK_HIGH = 1'b1
  } pack_state_e;

endpackage
